// File: cramBusIf.sv
`default_nettype none

interface cramBusIf;
  import cramPkg::*;

  // Fields of the current microword, driven from the output register.
  tCRADR                j;                            // Jump address.
  logic [skipWidth-1:0] skip;                         // Skip code.
  logic [dispWidth-1:0] disp;                         // Dispatch code.
  logic                 call;                         // Call flag.
  logic [restWidth-1:0] rest;                         // Datapath payload.

  // Control store side.
  modport store (
    output j, skip, disp, call, rest
  );

  // Skip and dispatch evaluators.
  modport eval (
    input skip, disp
  );

  // Next address logic.
  modport seq (
    input j, call
  );

endinterface

`default_nettype wire

// File: cramPkg.sv
`default_nettype none

package cramPkg;

  // Store geometry.
  localparam int cramWidth  = 84;                     // Bits per microword.
  localparam int cradrWidth = 11;                     // Control address bits.
  localparam int cramDepth  = 2048;                   // Words in the store.

  // Field widths of the microword, MSB first.
  localparam int jWidth     = cradrWidth;             // Jump address.
  localparam int skipWidth  = 6;                      // Skip condition code.
  localparam int dispWidth  = 5;                      // Dispatch code.
  localparam int callWidth  = 1;                      // Subroutine call flag.
  localparam int restWidth  = cramWidth - jWidth - skipWidth
                              - dispWidth - callWidth; // Datapath bits, 61.

  // Control RAM address.
  typedef logic [cradrWidth-1:0] tCRADR;

  // One microword as seen by the sequencer.
  // The datapath fields (AD, AR, SCAD and so on) stay packed in rest.
  typedef struct packed {
    tCRADR                j;                          // Next address base.
    logic [skipWidth-1:0] skip;                       // Forces bit 0 of J.
    logic [dispWidth-1:0] disp;                       // ORs into J or returns.
    logic                 call;                       // Push return address.
    logic [restWidth-1:0] rest;                       // Untouched payload.
  } tuCRAM;

endpackage

`default_nettype wire

// File: crm.sv
`default_nettype none

module crm (
  input  logic           eboxClk,
  input  logic           arstN,
  input  logic           run,                         // Execute one word per clock.
  input  logic           loadEn,                      // Console write strobe.
  input  cramPkg::tCRADR loadAddr,
  input  cramPkg::tuCRAM loadData,
  input  cramPkg::tCRADR cradr,                       // Read address for next word.
  cramBusIf.store        bus
);
  import cramPkg::*;

  tuCRAM cramMem [cramDepth];                         // The 2K word array.
  tuCRAM curWord;                                     // Word being executed.
  logic  loadWe;

  // Console loads only land while the machine is halted.
  assign loadWe = loadEn && !run;

  always_ff @(posedge eboxClk) begin
    if (loadWe) begin
      cramMem[loadAddr] <= loadData;                  // Microcode load.
    end
  end

  // Cleared on reset so execution starts from address zero.
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      curWord <= '0;
    end else if (run) begin
      curWord <= cramMem[cradr];                      // Fetch next microword.
    end
  end

  assign bus.j    = curWord.j;
  assign bus.skip = curWord.skip;
  assign bus.disp = curWord.disp;
  assign bus.call = curWord.call;
  assign bus.rest = curWord.rest;                     // Datapath bits pass on.

endmodule

`default_nettype wire

// File: crmTb.sv
`default_nettype none

module crmTb;
  import cramPkg::*;
  import seqPkg::*;

  localparam int halfPeriod   = 10;                   // Clock period of 20.
  localparam int resetCycles  = 5;
  localparam int dirWords     = 10;                   // Call and return program.
  localparam int dirRunCycles = 40;
  localparam int haltTotal    = 5;                    // Halts between phases.
  localparam int rndRunCycles = 1500;
  localparam int maxCycles    = resetCycles + dirWords + cramDepth + dirRunCycles
                                + haltTotal + rndRunCycles + 100;

  logic                    eboxClk;
  logic                    arstN;
  logic                    run;
  logic                    loadEn;
  tCRADR                   loadAddr;
  tuCRAM                   loadData;
  logic [statusWidth-1:0]  status;
  logic [dispSrcWidth-1:0] dispSrc;
  tCRADR                   cradr;
  logic [cramWidth-1:0]    cramWord;

  tuCRAM cramCopy [cramDepth];                        // Model of the store.
  tuCRAM mdlWord;                                     // Expected current word.
  tCRADR mdlAdr;                                      // Its address.
  tCRADR mdlStack [stackDepth];                       // Entry 0 is the top.
  int    mdlCnt;
  int    errCnt;
  int    checkCnt;
  int    cycleCnt;

  crmTop dut_i (
    .eboxClk  (eboxClk),
    .arstN    (arstN),
    .run      (run),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .status   (status),
    .dispSrc  (dispSrc),
    .cradr    (cradr),
    .cramWord (cramWord)
  );

  initial begin
    eboxClk = 1'b0;
    forever #halfPeriod eboxClk = ~eboxClk;
  end

  // Expected next address from the word, the inputs and the stack top.
  function automatic tCRADR refNextAddr(input tuCRAM w, input logic [statusWidth-1:0] st,
                                        input logic [dispSrcWidth-1:0] ds,
                                        input tCRADR top, input int cnt);
    int                      code;
    logic                    skipBit;
    logic [dispSrcWidth-1:0] orBits;
    code = int'(w.skip);
    if (code >= int'(skipIfSet0) && code <= int'(skipIfSet7)) begin
      skipBit = st[code - int'(skipIfSet0)];          // Bit set.
    end else if (code >= int'(skipIfClr0) && code <= int'(skipIfClr7)) begin
      skipBit = ~st[code - int'(skipIfClr0)];         // Bit clear.
    end else begin
      skipBit = (code == int'(skipAlways));           // Undefined codes never skip.
    end
    if (w.disp == dispRet) begin
      return (cnt > 0) ? top : '0;                    // Empty pop gives zero.
    end
    if (w.disp == dispMul) begin
      orBits = {2'b00, ds[1:0]};
    end else if (w.disp == dispDram) begin
      orBits = ds;
    end else begin
      orBits = '0;
    end
    return w.j | tCRADR'(orBits) | tCRADR'(skipBit);
  endfunction

  task automatic checkVal(input string name, input logic [cramWidth-1:0] got,
                          input logic [cramWidth-1:0] exp);
    checkCnt++;
    if (got !== exp) begin
      errCnt++;
      $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  function automatic tuCRAM randWord();
    tuCRAM w;
    w.j    = cradrWidth'($urandom);
    w.skip = skipWidth'($urandom % 24);               // 18 defined, 6 undefined.
    w.disp = dispWidth'($urandom % 8);                // 4 defined, 4 undefined.
    w.call = (($urandom % 4) == 0);
    w.rest = restWidth'({$urandom, $urandom});
    return w;
  endfunction

  function automatic tuCRAM progWord(input tCRADR j, input tDisp disp, input logic call);
    tuCRAM w;
    w      = randWord();
    w.j    = j;
    w.skip = skipNever;
    w.disp = disp;
    w.call = call;
    return w;
  endfunction

  task automatic loadWord(input tCRADR addr, input tuCRAM word);
    @(negedge eboxClk);
    run         = 1'b0;
    loadEn      = 1'b1;
    loadAddr    = addr;
    loadData    = word;
    cramCopy[addr] = word;
  endtask

  // Running steps, optionally with loads that must be ignored.
  task automatic runSteps(input int n, input bit strayLoads);
    repeat (n) begin
      @(negedge eboxClk);
      run      = 1'b1;
      status   = statusWidth'($urandom);
      dispSrc  = dispSrcWidth'($urandom);
      loadEn   = strayLoads ? 1'($urandom % 2) : 1'b0;
      loadAddr = cradrWidth'($urandom);
      loadData = randWord();
    end
  endtask

  task automatic holdHalted(input int n);
    @(negedge eboxClk);
    run    = 1'b0;
    loadEn = 1'b0;
    repeat (n - 1) @(negedge eboxClk);
  endtask

  // Model state follows the DUT edge by edge.
  always @(posedge eboxClk) begin : compareProc
    tCRADR expAdr;
    if (!arstN) begin
      mdlWord = '0;
      mdlAdr  = '0;
      mdlCnt  = 0;
      for (int i = 0; i < stackDepth; i++) begin
        mdlStack[i] = '0;
      end
      checkVal("cradr", cramWidth'(cradr), '0);
      checkVal("cramWord", cramWord, '0);
    end else begin
      expAdr = refNextAddr(mdlWord, status, dispSrc, mdlStack[0], mdlCnt);
      checkVal("cradr", cramWidth'(cradr), cramWidth'(expAdr));
      checkVal("cramWord", cramWord, mdlWord);
      if (run) begin
        if (mdlWord.disp == dispRet && mdlCnt > 0) begin
          for (int i = 0; i < stackDepth - 1; i++) begin
            mdlStack[i] = mdlStack[i+1];             // Pop.
          end
          mdlCnt--;
        end
        if (mdlWord.call) begin
          for (int i = stackDepth - 1; i > 0; i--) begin
            mdlStack[i] = mdlStack[i-1];             // Oldest drops off.
          end
          mdlStack[0] = mdlAdr + tCRADR'(1);
          if (mdlCnt < stackDepth) begin
            mdlCnt++;
          end
        end
        mdlAdr  = expAdr;
        mdlWord = cramCopy[expAdr];
      end
    end
  end

  initial begin : watchdog
    cycleCnt = 0;
    while (cycleCnt <= maxCycles) begin
      @(posedge eboxClk);
      cycleCnt++;
    end
    $display("Timeout: the run did not end within %0d clock cycles", maxCycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    int assertFails;
    arstN    = 1'b0;
    run      = 1'b0;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    status   = '0;
    dispSrc  = '0;
    errCnt   = 0;
    checkCnt = 0;
    void'($urandom(32'h8951));
    for (int i = 0; i < cramDepth; i++) begin
      cramCopy[i] = '0;
    end
    repeat (resetCycles) @(negedge eboxClk);
    arstN = 1'b1;
    // Five nested calls, then five returns; the last one pops an empty stack.
    loadWord(11'h000, progWord(11'h100, dispNone, 1'b1));
    loadWord(11'h100, progWord(11'h200, dispNone, 1'b1));
    loadWord(11'h200, progWord(11'h300, dispNone, 1'b1));
    loadWord(11'h300, progWord(11'h400, dispNone, 1'b1));
    loadWord(11'h400, progWord(11'h500, dispNone, 1'b1));
    loadWord(11'h500, progWord(11'h000, dispRet, 1'b0));
    loadWord(11'h401, progWord(11'h000, dispRet, 1'b0));
    loadWord(11'h301, progWord(11'h000, dispRet, 1'b0));
    loadWord(11'h201, progWord(11'h000, dispRet, 1'b0));
    loadWord(11'h101, progWord(11'h000, dispRet, 1'b0));
    runSteps(25, 1'b0);
    holdHalted(3);                                    // Word must hold.
    runSteps(dirRunCycles - 25, 1'b0);
    for (int a = 0; a < cramDepth; a++) begin
      loadWord(tCRADR'(a), randWord());               // Reload while halted.
    end
    runSteps(rndRunCycles, 1'b1);
    holdHalted(2);
    assertFails = dut_i.asserts_i.failCnt;
    $display("Checks %0d, errors %0d, assertion failures %0d", checkCnt, errCnt,
             assertFails);
    if (errCnt == 0 && assertFails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: crmTb_asserts.sv
`default_nettype none

module crmAsserts (
  input logic                          eboxClk,
  input logic                          arstN,
  input logic                          run,
  input cramPkg::tCRADR                cradr,
  input logic [cramPkg::cramWidth-1:0] cramWord
);

  int failCnt = 0;                                    // Failed assertions so far.

  // Halted machine keeps its word.
  holdWhenHalted: assert property (
    @(posedge eboxClk) disable iff (!arstN) !run |=> $stable(cramWord)
  ) else begin
    failCnt++;
    $error("cramWord changed while run was low");
  end

  // Cleared word means address zero.
  zeroAdrInReset: assert property (
    @(posedge eboxClk) !arstN |-> cradr == '0
  ) else begin
    failCnt++;
    $error("cradr is not zero during reset");
  end

  wordKnown: assert property (
    @(posedge eboxClk) disable iff (!arstN) !$isunknown(cramWord)
  ) else begin
    failCnt++;
    $error("cramWord has unknown bits after reset");
  end

endmodule

bind crmTop crmAsserts asserts_i (
  .eboxClk  (eboxClk),
  .arstN    (arstN),
  .run      (run),
  .cradr    (cradr),
  .cramWord (cramWord)
);

`default_nettype wire

// File: crmTop.sv
`default_nettype none

module crmTop (
  input  logic                            eboxClk,
  input  logic                            arstN,
  input  logic                            run,
  input  logic                            loadEn,
  input  cramPkg::tCRADR                  loadAddr,
  input  logic [cramPkg::cramWidth-1:0]   loadData,   // Raw microword to store.
  input  logic [seqPkg::statusWidth-1:0]  status,
  input  logic [seqPkg::dispSrcWidth-1:0] dispSrc,
  output cramPkg::tCRADR                  cradr,
  output logic [cramPkg::cramWidth-1:0]   cramWord    // Current microword.
);
  import cramPkg::*;
  import seqPkg::*;

  cramBusIf bus ();                                   // Current word fields.

  logic                    skipTaken;                 // Forces address bit 0.
  logic [dispSrcWidth-1:0] dispOr;                    // Low bits from dispatch.
  logic                    retReq;                    // Pop the return stack.

  crm crm_i (
    .eboxClk  (eboxClk),
    .arstN    (arstN),
    .run      (run),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (tuCRAM'(loadData)),
    .cradr    (cradr),
    .bus      (bus.store)
  );

  skipEval skipEval_i (
    .bus       (bus.eval),
    .status    (status),
    .skipTaken (skipTaken)
  );

  dispEval dispEval_i (
    .bus     (bus.eval),
    .dispSrc (dispSrc),
    .dispOr  (dispOr),
    .retReq  (retReq)
  );

  nextAddr nextAddr_i (
    .eboxClk   (eboxClk),
    .arstN     (arstN),
    .run       (run),
    .bus       (bus.seq),
    .skipTaken (skipTaken),
    .dispOr    (dispOr),
    .retReq    (retReq),
    .cradr     (cradr)
  );

  // Fields back in microword order, MSB first.
  assign cramWord = {bus.j, bus.skip, bus.disp, bus.call, bus.rest};

endmodule

`default_nettype wire

// File: dispEval.sv
`default_nettype none

module dispEval (
  cramBusIf.eval                          bus,
  input  logic [seqPkg::dispSrcWidth-1:0] dispSrc,    // Dispatch source.
  output logic [seqPkg::dispSrcWidth-1:0] dispOr,     // ORed into low J bits.
  output logic                            retReq      // Take address from stack.
);
  import seqPkg::*;

  tDisp code;

  assign code = tDisp'(bus.disp);

  always_comb begin
    dispOr = '0;
    retReq = 1'b0;
    case (code)
      dispMul: begin
        dispOr = {2'b00, dispSrc[1:0]};               // Four way branch.
      end
      dispDram: begin
        dispOr = dispSrc;                             // Sixteen way branch.
      end
      dispRet: begin
        retReq = 1'b1;                                // Subroutine return.
      end
      default: begin
        dispOr = '0;                                  // J used unchanged.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: nextAddr.sv
`default_nettype none

module nextAddr (
  input  logic                            eboxClk,
  input  logic                            arstN,
  input  logic                            run,
  cramBusIf.seq                           bus,
  input  logic                            skipTaken,
  input  logic [seqPkg::dispSrcWidth-1:0] dispOr,
  input  logic                            retReq,
  output cramPkg::tCRADR                  cradr       // Address of next word.
);
  import cramPkg::*;
  import seqPkg::*;

  tCRADR                    curAdr;                   // Address of current word.
  tCRADR                    retAdr;                   // Value pushed on call.
  tCRADR                    popAdr;                   // Top of stack or zero.
  tCRADR                    jumpAdr;
  tCRADR                    stack [stackDepth];       // Entry 0 is the top.
  logic [stackCntWidth-1:0] stackCnt;                 // Valid entries.

  assign retAdr = curAdr + tCRADR'(1);

  // Empty stack returns to zero.
  assign popAdr = (stackCnt != '0) ? stack[0] : '0;

  // Dispatch bits and skip bit are merged into J.
  assign jumpAdr = bus.j | tCRADR'(dispOr) | tCRADR'(skipTaken);

  assign cradr = retReq ? popAdr : jumpAdr;

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      curAdr   <= '0;
      stackCnt <= '0;
      for (int i = 0; i < stackDepth; i++) begin
        stack[i] <= '0;
      end
    end else if (run) begin
      curAdr <= cradr;                                // Tracks the fetched word.
      if (retReq && bus.call) begin
        // Pop then push leaves only the top replaced.
        stack[0] <= retAdr;
        if (stackCnt == '0) begin
          stackCnt <= stackCntWidth'(1);
        end
      end else if (bus.call) begin
        stack[0] <= retAdr;                           // Oldest entry falls off.
        for (int i = 1; i < stackDepth; i++) begin
          stack[i] <= stack[i-1];
        end
        if (stackCnt != stackCntWidth'(stackDepth)) begin
          stackCnt <= stackCnt + stackCntWidth'(1);
        end
      end else if (retReq) begin
        for (int i = 0; i < stackDepth - 1; i++) begin
          stack[i] <= stack[i+1];                     // Shift up.
        end
        stack[stackDepth-1] <= '0;                    // Keep unused slots zero.
        if (stackCnt != '0) begin
          stackCnt <= stackCnt - stackCntWidth'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module crmTb -o crmSim \
  > build.log 2>&1 || { cat build.log; echo "Build of crmTb failed"; exit 1; }

./obj_dir/crmSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: seqPkg.sv
`default_nettype none

package seqPkg;

  localparam int statusWidth   = 8;                   // Skip condition inputs.
  localparam int dispSrcWidth  = 4;                   // Dispatch source bits.
  localparam int stackDepth    = 4;                   // Return stack entries.
  localparam int stackCntWidth = $clog2(stackDepth + 1); // Counts 0 to 4.

  // Skip codes. Unlisted values never skip.
  typedef enum logic [cramPkg::skipWidth-1:0] {
    skipNever  = 6'd0,
    skipIfSet0 = 6'd1,                                // Status bit set.
    skipIfSet1 = 6'd2,
    skipIfSet2 = 6'd3,
    skipIfSet3 = 6'd4,
    skipIfSet4 = 6'd5,
    skipIfSet5 = 6'd6,
    skipIfSet6 = 6'd7,
    skipIfSet7 = 6'd8,
    skipIfClr0 = 6'd9,                                // Status bit clear.
    skipIfClr1 = 6'd10,
    skipIfClr2 = 6'd11,
    skipIfClr3 = 6'd12,
    skipIfClr4 = 6'd13,
    skipIfClr5 = 6'd14,
    skipIfClr6 = 6'd15,
    skipIfClr7 = 6'd16,
    skipAlways = 6'd17
  } tSkip;

  // Dispatch codes. Unlisted values act as dispNone.
  typedef enum logic [cramPkg::dispWidth-1:0] {
    dispNone = 5'd0,
    dispMul  = 5'd1,                                  // Two source bits.
    dispDram = 5'd2,                                  // Four source bits.
    dispRet  = 5'd3                                   // Pop return stack.
  } tDisp;

endpackage

`default_nettype wire

// File: skipEval.sv
`default_nettype none

module skipEval (
  cramBusIf.eval                      bus,
  input  logic [seqPkg::statusWidth-1:0] status,      // Condition inputs.
  output logic                        skipTaken       // Forces CRADR bit 0.
);
  import seqPkg::*;

  tSkip       code;
  logic [2:0] setIdx;                                 // Bit for the set group.
  logic [2:0] clrIdx;                                 // Bit for the clear group.

  assign code = tSkip'(bus.skip);

  // Offsets into each group of eight.
  assign setIdx = 3'(code - skipIfSet0);
  assign clrIdx = 3'(code - skipIfClr0);

  always_comb begin
    case (code) inside
      [skipIfSet0:skipIfSet7]: begin
        skipTaken = status[setIdx];                   // True polarity.
      end
      [skipIfClr0:skipIfClr7]: begin
        skipTaken = ~status[clrIdx];                  // Inverted polarity.
      end
      skipAlways: begin
        skipTaken = 1'b1;
      end
      default: begin
        skipTaken = 1'b0;                             // Never, and undefined codes.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: sources.f
cramPkg.sv
seqPkg.sv
cramBusIf.sv
crm.sv
skipEval.sv
dispEval.sv
nextAddr.sv
crmTop.sv
crmTb_asserts.sv
crmTb.sv
